// ==== vlog.f ====
+incdir+include
src/cache_pkg.sv
src/cache_ifs.sv
src/bank_router.sv
src/cache_bank.sv
src/refill_arbiter.sv
src/snowball_cache_top.sv
verification/tb_apb_mem.sv
verification/tb_snowball_cache.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f \
  --top-module tb_snowball_cache -Mdir obj_dir

out=$(./obj_dir/Vtb_snowball_cache 2>&1 || true)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "TESTBENCH PASSED"

// ==== verification/tb_snowball_cache.sv ====
`include "cache_cfg.svh"

module tb_snowball_cache;

  import cache_pkg::*;

  localparam int TIMEOUT_CYCLES = 60;
  localparam int NUM_RANDOM     = 300;
  localparam int TAG_W          = 32 - `TAG_LSB;

  logic        CPU_CLK = 1'b0;
  logic        RST_CPU;
  logic        cpu_valid, cpu_we, cpu_force_miss;
  cache_word_t cpu_addr, cpu_wdata, cpu_rdata;
  logic        cpu_busy, cpu_rvalid, cpu_err;
  logic        psel, penable, pwrite, pready, pslverr;
  cache_word_t paddr, pwdata, prdata;

  // ------------------------------------------------------------
  // reference model
  // ------------------------------------------------------------
  cache_word_t      mem_img [cache_word_t];
  logic             shadow_vld [`NUM_BANKS][1 << `INDEX_BITS];
  logic [TAG_W-1:0] shadow_tag [`NUM_BANKS][1 << `INDEX_BITS];

  int seed      = 59;
  int issued    = 0;
  int rsp_count = 0;

  always #10 CPU_CLK = ~CPU_CLK;

  snowball_cache_top dut_i (.*);
  tb_apb_mem mem_i (.*);

  always @(negedge CPU_CLK)
    if (cpu_rvalid)
      rsp_count++;   // one per pulse

  function automatic cache_word_t mem_fill(input cache_word_t a);
    return {a[15:0], a[31:16]} ^ (a * 32'h9E37_79B1);
  endfunction

  function automatic cache_word_t model_read(input cache_word_t a);
    return mem_img.exists(a) ? mem_img[a] : mem_fill(a);
  endfunction

  // few tags and indexes so lines hit and conflict
  function automatic cache_word_t pick_addr(input int r);
    logic [TAG_W-1:0] tag;
    case (r[2:0])
      3'd0, 3'd1, 3'd2: tag = 22'h000000;
      3'd3, 3'd4:       tag = 22'h000001;
      3'd5, 3'd6:       tag = 22'h0155AA;
      default:          tag = 22'h3C0011;   // error region
    endcase
    return {tag, 4'b0000, r[4:3], r[6:5], 2'b00};
  endfunction

  task automatic stop_on_error(input string msg);
    $display("error at %0t: %s", $time, msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_rdata(input cache_word_t got, input cache_word_t exp,
                             input cache_word_t addr);
    if (got !== exp)
      stop_on_error($sformatf("cpu_rdata for %h is %h, expected %h", addr, got, exp));
  endtask

  task automatic check_err(input logic got, input logic exp, input cache_word_t addr);
    if (got !== exp)
      stop_on_error($sformatf("cpu_err for %h is %b, expected %b", addr, got, exp));
  endtask

  // one request, from drive to checked response
  task automatic issue_request(input logic we, input cache_word_t addr,
                               input cache_word_t wdata, input logic force_miss,
                               input logic hold);
    logic [`BANK_BITS-1:0]  bank;
    logic [`INDEX_BITS-1:0] idx;
    logic                   exp_hit;
    logic                   exp_err;
    logic                   saw_psel;
    logic                   got_rsp;
    cache_word_t            prev_rdata;
    int                     cycles;
    bank       = addr[`BANK_LSB +: `BANK_BITS];
    idx        = addr[`INDEX_LSB +: `INDEX_BITS];
    exp_err    = (addr[31:28] == `ERR_REGION);
    exp_hit    = !we && !force_miss && shadow_vld[bank][idx]
                 && (shadow_tag[bank][idx] == addr[31:`TAG_LSB]);
    prev_rdata = cpu_rdata;
    issued++;
    cpu_valid      = 1'b1;
    cpu_we         = we;
    cpu_addr       = addr;
    cpu_wdata      = wdata;
    cpu_force_miss = force_miss;
    cycles = 0;
    do
    begin
      @(posedge CPU_CLK);
      #1;
      cycles++;
      if (cycles > TIMEOUT_CYCLES)
        stop_on_error("timeout, the request was never accepted");
    end
    while (!cpu_busy);
    if (!hold)
      cpu_valid = 1'b0;   // held requests stay up through busy
    cycles   = 0;
    saw_psel = 1'b0;
    got_rsp  = 1'b0;
    while (!got_rsp)
    begin
      @(posedge CPU_CLK);
      #1;
      cycles++;
      saw_psel = saw_psel | psel;
      if (cpu_rvalid)
        got_rsp = 1'b1;
      else if (!cpu_busy)
        stop_on_error("cpu_busy fell before the response arrived");
      else if (cycles > TIMEOUT_CYCLES)
        stop_on_error("timeout, no cpu_rvalid for an accepted request");
    end
    cpu_valid = 1'b0;
    check_err(cpu_err, exp_err, addr);
    if (we)
      check_rdata(cpu_rdata, prev_rdata, addr);   // writes leave it alone
    else if (!exp_err)
      check_rdata(cpu_rdata, model_read(addr), addr);
    if (exp_hit && (cycles != 2 || saw_psel))
      stop_on_error($sformatf("read hit at %h took %0d cycles or used APB", addr, cycles));
    if (!exp_hit && !saw_psel)
      stop_on_error("a miss, forced miss or write finished without an APB transfer");
    if (we && !exp_err)
      mem_img[addr] = wdata;
    if (!we && !exp_hit && !exp_err)
    begin
      shadow_vld[bank][idx] = 1'b1;   // refilled line
      shadow_tag[bank][idx] = addr[31:`TAG_LSB];
    end
  endtask

  initial
  begin
    cache_word_t a;
    cache_word_t b;
    cache_word_t e;
    int          r;
    int          ra;
    int          rd;
    RST_CPU        = 1'b1;
    cpu_valid      = 1'b0;
    cpu_we         = 1'b0;
    cpu_force_miss = 1'b0;
    cpu_addr       = '0;
    cpu_wdata      = '0;
    foreach (shadow_vld[i, j])
      shadow_vld[i][j] = 1'b0;
    repeat (2) @(posedge CPU_CLK);
    #1;
    RST_CPU = 1'b0;
    if (cpu_busy || cpu_rvalid || psel || penable)
      stop_on_error("outputs are not idle after reset");

    // ------------------------------------------------------------
    // directed sequence
    // ------------------------------------------------------------
    a = 32'h0000_0054;   // index 5, bank 1
    b = 32'h0000_8454;   // same line, other tag
    e = 32'hF000_0128;
    issue_request(1'b1, a, 32'h1111_2222, 1'b0, 1'b0);   // write, no allocate
    issue_request(1'b0, a, '0, 1'b0, 1'b0);              // miss and refill
    issue_request(1'b0, a, '0, 1'b0, 1'b1);              // hit, valid held
    issue_request(1'b1, a, 32'h3333_4444, 1'b0, 1'b1);   // write to cached line
    issue_request(1'b0, a, '0, 1'b0, 1'b0);
    issue_request(1'b0, a, '0, 1'b1, 1'b0);              // forced miss
    issue_request(1'b0, b, '0, 1'b0, 1'b0);              // evicts a
    issue_request(1'b0, a, '0, 1'b0, 1'b0);
    issue_request(1'b0, e, '0, 1'b0, 1'b0);              // slave error
    issue_request(1'b0, e, '0, 1'b0, 1'b0);              // not filled, APB again
    issue_request(1'b1, e, 32'hDEAD_0001, 1'b0, 1'b0);

    // random traffic over all banks
    for (int n = 0; n < NUM_RANDOM; n++)
    begin
      r  = $random(seed);
      ra = $random(seed);
      rd = $random(seed);
      issue_request(r[7:5] < 3'd3, pick_addr(ra), rd, r[10:8] == 3'd0, r[11]);
    end

    repeat (5) @(posedge CPU_CLK);
    #1;
    if (cpu_busy || rsp_count != issued)
      stop_on_error($sformatf("%0d requests issued but %0d responses seen",
                              issued, rsp_count));
    else
    begin
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

endmodule

// ==== verification/tb_apb_mem.sv ====
`include "cache_cfg.svh"

module tb_apb_mem
  (input  logic                   CPU_CLK,
   input  logic                   RST_CPU,
   input  logic                   psel,
   input  logic                   penable,
   input  logic                   pwrite,
   input  cache_pkg::cache_word_t paddr,
   input  cache_pkg::cache_word_t pwdata,
   output cache_pkg::cache_word_t prdata,
   output logic                   pready,
   output logic                   pslverr);

  import cache_pkg::*;

  int          seed = 59;
  int          draw;
  logic [1:0]  wait_cnt;
  logic        go;                      // response goes out next cycle
  logic        in_err;
  cache_word_t mem_q [cache_word_t];    // only written words stored

  assign in_err = (paddr[31:28] == `ERR_REGION);

  // unwritten words, built from the whole address
  function automatic cache_word_t mem_fill(input cache_word_t a);
    return {a[15:0], a[31:16]} ^ (a * 32'h9E37_79B1);
  endfunction

  initial
  begin
    pready  = 1'b0;
    pslverr = 1'b0;
    prdata  = '0;
  end

  always @(posedge CPU_CLK)
  begin
    if (RST_CPU)
    begin
      pready   <= 1'b0;
      pslverr  <= 1'b0;
      prdata   <= '0;
      wait_cnt <= '0;
    end
    else
    begin
      go = 1'b0;
      if (psel && !penable)
      begin
        draw     = $random(seed);   // 0 to 3 wait states
        wait_cnt <= draw[1:0];
        go       = (draw[1:0] == 2'd0);
      end
      else if (psel && !pready)
      begin
        wait_cnt <= wait_cnt - 2'd1;
        go       = (wait_cnt == 2'd1);
      end
      else if (psel && pwrite && !in_err)
        mem_q[paddr] = pwdata;      // completing edge
      pready  <= go;
      pslverr <= go && in_err;
      if (go && !pwrite)
        prdata <= mem_q.exists(paddr) ? mem_q[paddr] : mem_fill(paddr);
    end
  end

endmodule

// ==== src/snowball_cache_top.sv ====
`include "cache_cfg.svh"

module snowball_cache_top
  (input  logic                   CPU_CLK,
   input  logic                   RST_CPU,
   // cpu side
   input  logic                   cpu_valid,
   input  logic                   cpu_we,
   input  cache_pkg::cache_word_t cpu_addr,
   input  cache_pkg::cache_word_t cpu_wdata,
   input  logic                   cpu_force_miss,
   output logic                   cpu_busy,
   output logic                   cpu_rvalid,
   output cache_pkg::cache_word_t cpu_rdata,
   output logic                   cpu_err,
   // apb side
   output logic                   psel,
   output logic                   penable,
   output logic                   pwrite,
   output cache_pkg::cache_word_t paddr,
   output cache_pkg::cache_word_t pwdata,
   input  cache_pkg::cache_word_t prdata,
   input  logic                   pready,
   input  logic                   pslverr);

  bank_req_if breq [`NUM_BANKS] ();   // router to banks
  mem_req_if  mreq [`NUM_BANKS] ();   // banks to arbiter

  bank_router router_i
    (.CPU_CLK        (CPU_CLK),
     .RST_CPU        (RST_CPU),
     .cpu_valid      (cpu_valid),
     .cpu_we         (cpu_we),
     .cpu_force_miss (cpu_force_miss),
     .cpu_addr       (cpu_addr),
     .cpu_wdata      (cpu_wdata),
     .cpu_busy       (cpu_busy),
     .cpu_rvalid     (cpu_rvalid),
     .cpu_err        (cpu_err),
     .cpu_rdata      (cpu_rdata),
     .banks          (breq));

  // ------------------------------------------------------------
  // banks
  // ------------------------------------------------------------
  for (genvar i = 0; i < `NUM_BANKS; i++)
  begin : g_bank
    cache_bank bank_i
      (.CPU_CLK (CPU_CLK),
       .RST_CPU (RST_CPU),
       .req     (breq[i]),
       .mem     (mreq[i]));
  end

  refill_arbiter arbiter_i
    (.CPU_CLK (CPU_CLK),
     .RST_CPU (RST_CPU),
     .mem     (mreq),
     .psel    (psel),
     .penable (penable),
     .pwrite  (pwrite),
     .paddr   (paddr),
     .pwdata  (pwdata),
     .prdata  (prdata),
     .pready  (pready),
     .pslverr (pslverr));

endmodule

// ==== src/refill_arbiter.sv ====
`include "cache_cfg.svh"

module refill_arbiter
  (input  logic                   CPU_CLK,
   input  logic                   RST_CPU,
   mem_req_if.arbiter             mem [`NUM_BANKS],
   output logic                   psel,
   output logic                   penable,
   output logic                   pwrite,
   output cache_pkg::cache_word_t paddr,
   output cache_pkg::cache_word_t pwdata,
   input  cache_pkg::cache_word_t prdata,
   input  logic                   pready,
   input  logic                   pslverr);

  import cache_pkg::*;

  apb_state_e            state;
  logic [`BANK_BITS-1:0] rr_ptr;     // highest priority bank next round
  logic [`BANK_BITS-1:0] pick;
  logic [`BANK_BITS-1:0] gnt_q;
  logic                  any_req;
  logic                  grant;
  logic                  done_q;
  logic                  err_q;
  cache_word_t           rdata_q;
  logic [`NUM_BANKS-1:0] req_vec;
  mem_op_e               op_vec    [`NUM_BANKS];
  cache_word_t           addr_vec  [`NUM_BANKS];
  cache_word_t           wdata_vec [`NUM_BANKS];

  for (genvar i = 0; i < `NUM_BANKS; i++)
  begin : g_port
    assign req_vec[i]   = mem[i].req;
    assign op_vec[i]    = mem[i].op;
    assign addr_vec[i]  = mem[i].addr;
    assign wdata_vec[i] = mem[i].wdata;
    assign mem[i].done  = done_q && (gnt_q == `BANK_BITS'(i));
    assign mem[i].err   = err_q;
    assign mem[i].rdata = rdata_q;
  end

  // ------------------------------------------------------------
  // round-robin pick where the lowest offset from rr_ptr wins
  // ------------------------------------------------------------
  always_comb
  begin : rr_pick
    logic [`BANK_BITS-1:0] cand;
    pick    = rr_ptr;
    any_req = 1'b0;
    for (int k = `NUM_BANKS - 1; k >= 0; k--)
    begin
      cand = rr_ptr + `BANK_BITS'(k);
      if (req_vec[cand])
      begin
        pick    = cand;
        any_req = 1'b1;
      end
    end
  end

  // granted bank still holds req while done is out
  assign grant = (state == apb_idle) && any_req && !done_q;

  always_ff @(posedge CPU_CLK)
  begin
    if (RST_CPU)
    begin
      state   <= apb_idle;
      psel    <= 1'b0;
      penable <= 1'b0;
      done_q  <= 1'b0;
      rr_ptr  <= '0;
      gnt_q   <= '0;
    end
    else
    begin
      done_q <= 1'b0;
      case (state)
        apb_idle:
          if (grant)
          begin
            gnt_q  <= pick;
            rr_ptr <= pick + `BANK_BITS'(1);
            psel   <= 1'b1;
            state  <= apb_setup;
          end
        apb_setup:
        begin
          penable <= 1'b1;
          state   <= apb_access;
        end
        default:
          if (pready)
          begin
            psel    <= 1'b0;
            penable <= 1'b0;
            done_q  <= 1'b1;   // pulse in the cycle after pready
            state   <= apb_idle;
          end
      endcase
    end
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (grant)
    begin
      paddr  <= addr_vec[pick];
      pwdata <= wdata_vec[pick];
      pwrite <= (op_vec[pick] == op_write);
    end
    if (state == apb_access && pready)
    begin
      rdata_q <= prdata;
      err_q   <= pslverr;
    end
  end

  a_penable_psel: assert property (@(posedge CPU_CLK) disable iff (RST_CPU)
    penable |-> psel);

  // address and data fixed for the whole transfer
  a_apb_stable: assert property (@(posedge CPU_CLK) disable iff (RST_CPU)
    psel && !(penable && pready) |=> $stable(paddr) && $stable(pwdata));

endmodule

// ==== src/cache_bank.sv ====
`include "cache_cfg.svh"

module cache_bank
  (input  logic    CPU_CLK,
   input  logic    RST_CPU,
   bank_req_if.bank req,
   mem_req_if.bank  mem);

  import cache_pkg::*;

  localparam int DEPTH = 1 << `INDEX_BITS;
  localparam int TAG_W = 32 - `TAG_LSB;

  // ------------------------------------------------------------
  // storage
  // ------------------------------------------------------------
  logic [DEPTH-1:0] valid_bits;
  logic [TAG_W-1:0] tag_mem  [DEPTH];
  cache_word_t      data_mem [DEPTH];

  bank_state_e      state;
  logic             take;

  // request latched on the accepting edge
  mem_op_e          op_q;
  cache_word_t      addr_q;
  cache_word_t      wdata_q;
  logic             force_miss_q;

  // array read data valid from bk_lookup on
  logic             vld_rd;
  logic [TAG_W-1:0] tag_rd;
  cache_word_t      data_rd;

  logic [`INDEX_BITS-1:0] req_idx;
  logic [`INDEX_BITS-1:0] cur_idx;
  logic             tag_match;
  logic             hit;

  assign req.ready = (state == bk_idle);
  assign take      = req.valid && req.ready;
  assign req_idx   = req.addr[`INDEX_LSB +: `INDEX_BITS];
  assign cur_idx   = addr_q[`INDEX_LSB +: `INDEX_BITS];
  assign tag_match = vld_rd && (tag_rd == addr_q[31:`TAG_LSB]);
  assign hit       = tag_match && (op_q == op_read) && !force_miss_q;

  assign mem.op    = op_q;
  assign mem.addr  = addr_q;
  assign mem.wdata = wdata_q;

  // ------------------------------------------------------------
  // lookup FSM
  // ------------------------------------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (RST_CPU)
    begin
      state         <= bk_idle;
      valid_bits    <= '0;
      mem.req       <= 1'b0;
      req.rsp_valid <= 1'b0;
      req.rsp_err   <= 1'b0;
    end
    else
    begin
      req.rsp_valid <= 1'b0;
      req.rsp_err   <= 1'b0;   // only alongside rsp_valid
      case (state)
        bk_idle:
          if (take)
            state <= bk_lookup;
        bk_lookup:
          if (hit)
          begin
            req.rsp_valid <= 1'b1;
            state         <= bk_respond;
          end
          else
          begin
            mem.req <= 1'b1;   // miss, forced miss or write-through
            state   <= bk_wait_mem;
          end
        bk_wait_mem:
          if (mem.done)
          begin
            mem.req       <= 1'b0;
            req.rsp_valid <= 1'b1;
            req.rsp_err   <= mem.err;
            state         <= bk_respond;
            if (op_q == op_read && !mem.err)
              valid_bits[cur_idx] <= 1'b1;   // refill
          end
        default:
          state <= bk_idle;   // bk_respond lasts one cycle
      endcase
    end
  end

  // payload, arrays and response data
  always_ff @(posedge CPU_CLK)
  begin
    if (take)
    begin
      op_q         <= req.op;
      addr_q       <= req.addr;
      wdata_q      <= req.wdata;
      force_miss_q <= req.force_miss;
      vld_rd       <= valid_bits[req_idx];
      tag_rd       <= tag_mem[req_idx];
      data_rd      <= data_mem[req_idx];
    end
    if (state == bk_lookup && hit)
      req.rsp_data <= data_rd;
    if (state == bk_wait_mem && mem.done && op_q == op_read)
    begin
      req.rsp_data <= mem.rdata;
      if (!mem.err)
      begin
        tag_mem[cur_idx]  <= addr_q[31:`TAG_LSB];
        data_mem[cur_idx] <= mem.rdata;
      end
    end
    // write updates a cached line only and never allocates
    if (state == bk_wait_mem && mem.done && op_q == op_write && tag_match && !mem.err)
      data_mem[cur_idx] <= wdata_q;
  end

  // ------------------------------------------------------------
  // checks
  // ------------------------------------------------------------
  a_rsp_in_respond: assert property (@(posedge CPU_CLK) disable iff (RST_CPU)
    req.rsp_valid |-> state == bk_respond);

  a_req_held: assert property (@(posedge CPU_CLK) disable iff (RST_CPU)
    mem.req && !mem.done |=> mem.req && state == bk_wait_mem);

endmodule

// ==== src/bank_router.sv ====
`include "cache_cfg.svh"

module bank_router
  (input  logic                   CPU_CLK,
   input  logic                   RST_CPU,
   input  logic                   cpu_valid,
   input  logic                   cpu_we,
   input  logic                   cpu_force_miss,
   input  cache_pkg::cache_word_t cpu_addr,
   input  cache_pkg::cache_word_t cpu_wdata,
   output logic                   cpu_busy,
   output logic                   cpu_rvalid,
   output logic                   cpu_err,
   output cache_pkg::cache_word_t cpu_rdata,
   bank_req_if.router             banks [`NUM_BANKS]);

  import cache_pkg::*;

  logic [`BANK_BITS-1:0] sel_bank;
  logic [`BANK_BITS-1:0] owner_q;     // bank serving the open request
  logic                  owner_we_q;
  logic                  accept;
  logic                  rsp_hit;
  mem_op_e               cpu_op;
  logic [`NUM_BANKS-1:0] ready_vec;
  logic [`NUM_BANKS-1:0] rsp_valid_vec;
  logic [`NUM_BANKS-1:0] rsp_err_vec;
  cache_word_t           rsp_data_vec [`NUM_BANKS];

  assign sel_bank = cpu_addr[`BANK_LSB +: `BANK_BITS];
  assign cpu_op   = cpu_we ? op_write : op_read;
  assign accept   = cpu_valid && !cpu_busy && ready_vec[sel_bank];
  assign rsp_hit  = cpu_busy && rsp_valid_vec[owner_q];

  // ------------------------------------------------------------
  // fan out the request, gather responses
  // ------------------------------------------------------------
  for (genvar i = 0; i < `NUM_BANKS; i++)
  begin : g_bank
    // only the addressed bank sees valid
    assign banks[i].valid      = cpu_valid && !cpu_busy && (sel_bank == `BANK_BITS'(i));
    assign banks[i].op         = cpu_op;
    assign banks[i].addr       = cpu_addr;
    assign banks[i].wdata      = cpu_wdata;
    assign banks[i].force_miss = cpu_force_miss;
    assign ready_vec[i]        = banks[i].ready;
    assign rsp_valid_vec[i]    = banks[i].rsp_valid;
    assign rsp_err_vec[i]      = banks[i].rsp_err;
    assign rsp_data_vec[i]     = banks[i].rsp_data;
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (RST_CPU)
    begin
      cpu_busy   <= 1'b0;
      cpu_rvalid <= 1'b0;
      cpu_err    <= 1'b0;
      owner_q    <= '0;
      owner_we_q <= 1'b0;
    end
    else
    begin
      cpu_rvalid <= 1'b0;
      if (accept)
      begin
        cpu_busy   <= 1'b1;
        owner_q    <= sel_bank;
        owner_we_q <= cpu_we;
      end
      else if (rsp_hit)
      begin
        cpu_busy   <= 1'b0;
        cpu_rvalid <= 1'b1;   // second cycle of the hit latency
        cpu_err    <= rsp_err_vec[owner_q];
      end
    end
  end

  // write responses leave the read data alone
  always_ff @(posedge CPU_CLK)
  begin
    if (rsp_hit && !owner_we_q)
      cpu_rdata <= rsp_data_vec[owner_q];
  end

endmodule

// ==== src/cache_ifs.sv ====
// router to bank, one instance per bank
interface bank_req_if;
  import cache_pkg::*;

  logic        valid;
  mem_op_e     op;
  cache_word_t addr;
  cache_word_t wdata;
  logic        force_miss;
  logic        ready;       // high only in bk_idle
  logic        rsp_valid;   // one-cycle pulse
  logic        rsp_err;
  cache_word_t rsp_data;

  modport router (output valid, op, addr, wdata, force_miss,
                  input  ready, rsp_valid, rsp_err, rsp_data);
  modport bank   (input  valid, op, addr, wdata, force_miss,
                  output ready, rsp_valid, rsp_err, rsp_data);
endinterface

// bank to refill arbiter, req held until done
interface mem_req_if;
  import cache_pkg::*;

  logic        req;
  mem_op_e     op;
  cache_word_t addr;
  cache_word_t wdata;
  logic        done;        // err and rdata valid with it
  logic        err;
  cache_word_t rdata;

  modport bank    (output req, op, addr, wdata, input  done, err, rdata);
  modport arbiter (input  req, op, addr, wdata, output done, err, rdata);
endinterface

// ==== src/cache_pkg.sv ====
package cache_pkg;

  // ------------------------------------------------------------
  // shared word and opcode types
  // ------------------------------------------------------------

  typedef logic [31:0] cache_word_t;  // data or address word

  typedef enum logic
  {
    op_read  = 1'b0,
    op_write = 1'b1
  } mem_op_e;

  // ------------------------------------------------------------
  // state machines
  // ------------------------------------------------------------

  // per-bank lookup FSM
  typedef enum logic [1:0]
  {
    bk_idle     = 2'd0,
    bk_lookup   = 2'd1,   // arrays read, tag compare this cycle
    bk_wait_mem = 2'd2,
    bk_respond  = 2'd3
  } bank_state_e;

  // APB master in the arbiter
  typedef enum logic [1:0]
  {
    apb_idle   = 2'd0,
    apb_setup  = 2'd1,
    apb_access = 2'd2
  } apb_state_e;

endpackage

// ==== include/cache_cfg.svh ====
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// ------------------------------------------------------------
// address map
//   [31:10] tag   [9:4] index   [3:2] bank   [1:0] byte
// ------------------------------------------------------------

`define NUM_BANKS   4      // identical banks in the generate loop
`define BANK_BITS   2      // log2 of NUM_BANKS
`define BANK_LSB    2

`define INDEX_BITS  6      // 64 lines per bank
`define INDEX_LSB   4

`define TAG_LSB     10     // tag runs up to bit 31

// addr[31:28] value that the memory answers with pslverr
`define ERR_REGION  4'hF

`endif
